/* bench/fmModTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fmModTb
    import fmModRegPkg::*;
    import fmModDataPkg::*;
();

    localparam int clkPeriod      = 4;
    localparam int resetCycles    = 16;
    localparam int bitrate        = 15;
    localparam int bitPeriod      = 2 * (bitrate + 1);
    localparam int regIterations  = 48;
    localparam int bitClockCycles = 128;
    localparam int flushCycles    = 640;
    localparam int symbolCount    = 40;
    localparam int checkedSymbols = 4;
    localparam int runsPerMode    = 2;
    localparam int runCycles      = flushCycles + 18 + 2 * bitPeriod
                                    + symbolCount * 2 * bitPeriod;
    localparam int testCycles     = resetCycles + regIterations * 3 + 8 + bitClockCycles
                                    + 4 * runsPerMode * runCycles;

    logic      clk;
    logic      reset;
    logic      cs;
    logic      wr0;
    logic      wr1;
    logic      wr2;
    logic      wr3;
    busAddr_t  addr;
    busData_t  din;
    busData_t  dout;
    logic      txSelect;
    logic      modData;
    logic      modDataValid;
    logic      modClkIn;
    fskMode_e  fskMode;
    logic      modClkOut;
    freqWord_t fmModFreq;

    freqWord_t  carrier;
    deviation_t deviation;
    busData_t   shadow [4];

    fmMod dut (
        .clk(clk), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .txSelect(txSelect), .modData(modData), .modDataValid(modDataValid),
        .modClkIn(modClkIn), .fskMode(fskMode),
        .modClkOut(modClkOut), .fmModFreq(fmModFreq)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input string name, input busData_t actual, input busData_t expected);
        if (actual !== expected) begin
            $display("FAIL %0d ns %s: got %08h, expected %08h", $time, name, actual, expected);
            abortRun("bus word mismatch");
        end
    endtask

    task automatic checkFreq(input string name, input freqWord_t actual,
                             input freqWord_t expected);
        if (actual !== expected) begin
            $display("FAIL %0d ns %s: got %08h, expected %08h", $time, name, actual, expected);
            abortRun("frequency word mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %0d ns %s: got %b, expected %b", $time, name, actual, expected);
            abortRun("bit mismatch");
        end
    endtask

    function automatic busAddr_t regAddr(input int idx);
        case (idx)
            0:       return regCarrier;
            1:       return regDeviation;
            2:       return regBitrate;
            default: return regCicShift;
        endcase
    endfunction

    function automatic busData_t maskedMerge(input busData_t oldVal, input busData_t newVal,
                                             input logic [3:0] strobes);
        busData_t mask;
        mask = {{8{strobes[3]}}, {8{strobes[2]}}, {8{strobes[1]}}, {8{strobes[0]}}};
        return (oldVal & ~mask) | (newVal & mask);
    endfunction

    // Quarters of full deviation
    function automatic int levelFor(input fskMode_e mode, input logic [1:0] pattern);
        if (mode inside {mode2Fsk, modeShaped2Fsk}) begin
            return pattern[0] ? 2 : -2;
        end
        case (pattern)
            2'b00:   return 1;
            2'b01:   return 3;
            2'b10:   return -1;
            default: return -3;
        endcase
    endfunction

    function automatic freqWord_t expectedFreq(input fskMode_e mode, input logic [1:0] pattern);
        longint offset;
        // level/2 times deviation * 2^13
        offset = longint'(levelFor(mode, pattern)) * longint'(deviation) * 64'sd4096;
        if (mode[0]) begin
            offset = offset / 2;
        end
        return freqWord_t'(longint'(carrier) + offset);
    endfunction

    function automatic int cicShiftFor(input fskMode_e mode);
        int ratio;
        ratio = mode[1] ? bitPeriod : bitPeriod / 2;
        // Three stages give a gain of ratio^2
        return 2 * $clog2(ratio);
    endfunction

    task automatic busWrite(input busAddr_t a, input busData_t d, input logic [3:0] strobes);
        cs = 1'b1;
        addr = a;
        din = d;
        {wr3, wr2, wr1, wr0} = strobes;
        @(negedge clk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic busRead(input busAddr_t a, output busData_t value);
        cs = 1'b1;
        addr = a;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        @(negedge clk);
        cs = 1'b0;
        value = dout;
    endtask

    // Drive one bit until the next falling edge of modClkOut
    task automatic holdBit(input logic value, input bit verify, input freqWord_t expected);
        logic seenHigh;
        logic done;
        seenHigh = 1'b0;
        done = 1'b0;
        modData = value;
        while (!done) begin
            @(negedge clk);
            if (verify) begin
                checkFreq("fmModFreq", fmModFreq, expected);
            end
            if (modClkOut) begin
                seenHigh = 1'b1;
            end else if (seenHigh) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic runPattern(input fskMode_e mode, input logic [1:0] pattern);
        freqWord_t expected;
        bit        verify;
        expected = expectedFreq(mode, pattern);
        // Data off, pipeline drains back to the carrier
        modDataValid = 1'b0;
        repeat (flushCycles) @(negedge clk);
        repeat (16) begin
            @(negedge clk);
            checkFreq("fmModFreq", fmModFreq, carrier);
        end
        busWrite(regCicShift, busData_t'(cicShiftFor(mode)), 4'hF);
        fskMode = mode;
        holdBit(1'b0, 1'b0, carrier);
        modDataValid = 1'b1;
        for (int s = 0; s < symbolCount; s++) begin
            verify = (s >= symbolCount - checkedSymbols);
            if (mode[1]) begin
                holdBit(pattern[1], verify, expected);
                holdBit(pattern[0], verify, expected);
            end else begin
                holdBit(pattern[0], verify, expected);
            end
        end
    endtask

    initial begin
        busData_t   readVal;
        busData_t   data;
        logic [3:0] strobes;
        logic       expectedClk;
        int         idx;
        int         readIdx;
        void'($urandom(32'h2bc0));
        clk = 1'b0;
        reset = 1'b1;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr = '0;
        din = '0;
        txSelect = 1'b0;
        modData = 1'b0;
        modDataValid = 1'b0;
        modClkIn = 1'b0;
        fskMode = mode2Fsk;
        for (int i = 0; i < 4; i++) begin
            shadow[i] = '0;
        end
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        checkBit("modClkOut", modClkOut, 1'b0);
        checkFreq("fmModFreq", fmModFreq, '0);

        for (int n = 0; n < regIterations; n++) begin
            idx = $urandom % 4;
            data = $urandom;
            strobes = 4'($urandom);
            busWrite(regAddr(idx), data, strobes);
            shadow[idx] = maskedMerge(shadow[idx], data, strobes);
            readIdx = $urandom % 4;
            busRead(regAddr(readIdx), readVal);
            checkWord("dout", readVal, shadow[readIdx]);
        end

        carrier = $urandom;
        deviation = deviation_t'($urandom);
        busWrite(regBitrate, busData_t'(bitrate), 4'hF);
        busWrite(regCarrier, carrier, 4'hF);
        busWrite(regDeviation, busData_t'(deviation), 4'hF);
        repeat (2) @(negedge clk);

        // Divider starts from a full reload
        txSelect = 1'b1;
        expectedClk = 1'b0;
        for (int i = 1; i <= bitClockCycles; i++) begin
            @(negedge clk);
            if (i % (bitrate + 1) == 0) begin
                expectedClk = ~expectedClk;
            end
            checkBit("modClkOut", modClkOut, expectedClk);
        end

        for (int m = 0; m < 4; m++) begin
            for (int r = 0; r < runsPerMode; r++) begin
                runPattern(fskMode_e'(m), 2'($urandom));
            end
        end

        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(testCycles * 2 * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", testCycles * 2);
        abortRun("watchdog timeout");
    end

endmodule

`default_nettype wire

/* hw/fmDeviation.sv */
`timescale 1ns/1ps
`default_nettype none

module fmDeviation
    import fmModRegPkg::*;
    import fmModDataPkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire sample_t devInput,
    fmModCfgIf.dev       cfg,
    output freqWord_t    fmModFreq
);

    logic signed [36:0] product;

    // Deviation is unsigned so it gets a zero sign bit
    always_ff @(posedge clk) begin
        if (reset) begin
            product <= '0;
        end else begin
            product <= devInput * $signed({1'b0, cfg.deviation});
        end
    end

    always_ff @(posedge clk) begin
        fmModFreq <= freqWord_t'(product[34:3]) + cfg.carrierFreq;
    end

endmodule

`default_nettype wire

/* hw/fmInterpolate.sv */
`timescale 1ns/1ps
`default_nettype none

module fmInterpolate
    import fmModDataPkg::*;
#(
    parameter int cicStages = 3
) (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    sampleEn,
    input  wire sample_t dIn,
    fmModCfgIf.interp    cfg,
    output sample_t      devInput
);

    cicWide_t combDelay [cicStages];
    cicWide_t combIn    [cicStages+1];
    cicWide_t integ     [cicStages];
    cicWide_t integNext [cicStages];
    cicWide_t stuffed;

    // Comb chain at the sample rate
    always_comb begin
        combIn[0] = cicWide_t'(dIn);
        for (int k = 0; k < cicStages; k++) begin
            combIn[k+1] = combIn[k] - combDelay[k];
        end
    end

    // Zero stuffing between samples
    assign stuffed = sampleEn ? combIn[cicStages] : '0;

    always_comb begin
        integNext[0] = integ[0] + stuffed;
        for (int k = 1; k < cicStages; k++) begin
            integNext[k] = integ[k] + integNext[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < cicStages; k++) begin
                combDelay[k] <= '0;
                integ[k] <= '0;
            end
        end else begin
            for (int k = 0; k < cicStages; k++) begin
                if (sampleEn) begin
                    combDelay[k] <= combIn[k];
                end
                integ[k] <= integNext[k];
            end
        end
    end

    // Gain is R^(N-1), removed by the programmable shift
    always_ff @(posedge clk) begin
        devInput <= sample_t'(integ[cicStages-1] >>> cfg.cicShift);
    end

endmodule

`default_nettype wire

/* hw/fmMod.sv */
`timescale 1ns/1ps
`default_nettype none

module fmMod
    import fmModRegPkg::*;
    import fmModDataPkg::*;
#(
    parameter int cicStages = 3,
    parameter int firTaps   = 8
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cs,
    input  wire logic       wr0,
    input  wire logic       wr1,
    input  wire logic       wr2,
    input  wire logic       wr3,
    input  wire busAddr_t   addr,
    input  wire busData_t   din,
    output busData_t        dout,
    input  wire logic       txSelect,
    input  wire logic       modData,
    input  wire logic       modDataValid,
    input  wire logic       modClkIn,
    input  wire logic [1:0] fskMode,
    output logic            modClkOut,
    output freqWord_t       fmModFreq
);

    fskMode_e  mode;
    logic      shaped;
    logic      sampleStrobe;
    modLevel_t modValue;
    sample_t   shapedSample;
    logic      shapedStrobe;
    sample_t   levelSample;
    sample_t   interpInput;
    logic      interpStrobe;
    sample_t   devInput;

    fmModCfgIf cfg();

    assign mode   = fskMode_e'(fskMode);
    assign shaped = fskMode[0];

    fmModRegs regBlock (
        .clk(clk), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .cfg(cfg.regs)
    );

    fmSymbolControl symbolCtrl (
        .clk(clk), .reset(reset), .txSelect(txSelect),
        .modData(modData), .modDataValid(modDataValid),
        .modClkIn(modClkIn), .fskMode(mode), .cfg(cfg.ctrl),
        .modClkOut(modClkOut), .sampleStrobe(sampleStrobe), .modValue(modValue)
    );

    shapingFir #(.firTaps(firTaps)) pulseFir (
        .clk(clk), .reset(reset), .sampleStrobe(sampleStrobe), .modValue(modValue),
        .shapedSample(shapedSample), .shapedStrobe(shapedStrobe)
    );

    // Quarter levels to fraction: level * 2^15
    assign levelSample  = sample_t'(modValue) <<< 15;
    assign interpInput  = shaped ? shapedSample : levelSample;
    assign interpStrobe = shaped ? shapedStrobe : sampleStrobe;

    fmInterpolate #(.cicStages(cicStages)) cicInterp (
        .clk(clk), .reset(reset), .sampleEn(interpStrobe), .dIn(interpInput),
        .cfg(cfg.interp), .devInput(devInput)
    );

    fmDeviation devScale (
        .clk(clk), .reset(reset), .devInput(devInput),
        .cfg(cfg.dev), .fmModFreq(fmModFreq)
    );

endmodule

`default_nettype wire

/* hw/fmModCfgIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface fmModCfgIf
    import fmModRegPkg::*;
();

    freqWord_t   carrierFreq;
    deviation_t  deviation;
    bitrateDiv_t bitrateDiv;
    logic        modClkSel;
    cicShift_t   cicShift;

    modport regs (
        output carrierFreq,
        output deviation,
        output bitrateDiv,
        output modClkSel,
        output cicShift
    );

    // Bit clock generation
    modport ctrl (
        input bitrateDiv,
        input modClkSel
    );

    modport interp (
        input cicShift
    );

    modport dev (
        input carrierFreq,
        input deviation
    );

endinterface

`default_nettype wire

/* hw/fmModDataPkg.sv */
`default_nettype none

package fmModDataPkg;

    // Bit 0 set means the shaped variant
    typedef enum logic [1:0] {
        mode2Fsk       = 2'b00,
        modeShaped2Fsk = 2'b01,
        mode4Fsk       = 2'b10,
        modeShaped4Fsk = 2'b11
    } fskMode_e;

    // Level in quarters of full deviation
    typedef logic signed [2:0] modLevel_t;

    // Signed fraction, 2^17 is 1.0
    typedef logic signed [17:0] sample_t;

    typedef logic signed [33:0] cicWide_t;

    // Which bit of a 4FSK dibit comes next
    typedef enum logic {
        phaseFirst,
        phaseSecond
    } symPhase_e;

endpackage

`default_nettype wire

/* hw/fmModRegPkg.sv */
`default_nettype none

package fmModRegPkg;

    // NCO frequency word, used for the carrier and the output
    typedef logic [31:0] freqWord_t;

    typedef logic [17:0] deviation_t;
    typedef logic [15:0] bitrateDiv_t;
    typedef logic [4:0]  cicShift_t;

    // Bus side
    typedef logic [31:0] busData_t;
    typedef logic [11:0] busAddr_t;

    // Register map
    localparam busAddr_t regCarrier   = 12'h000;
    localparam busAddr_t regDeviation = 12'h004;
    // bitrateDiv in 15:0, modClkSel in 16
    localparam busAddr_t regBitrate   = 12'h008;
    localparam busAddr_t regCicShift  = 12'h00C;

    localparam int modClkSelBit = 16;

endpackage

`default_nettype wire

/* hw/fmModRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module fmModRegs
    import fmModRegPkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     cs,
    input  wire logic     wr0,
    input  wire logic     wr1,
    input  wire logic     wr2,
    input  wire logic     wr3,
    input  wire busAddr_t addr,
    input  wire busData_t din,
    output busData_t      dout,
    fmModCfgIf.regs       cfg
);

    busData_t   carrierReg;
    busData_t   deviationReg;
    busData_t   bitrateReg;
    busData_t   cicShiftReg;
    logic [3:0] byteWr;

    function automatic busData_t mergeBytes(busData_t oldVal, busData_t newVal,
                                            logic [3:0] strobes);
        busData_t result;
        result = oldVal;
        for (int i = 0; i < 4; i++) begin
            if (strobes[i]) begin
                result[8*i +: 8] = newVal[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign byteWr = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk) begin
        if (reset) begin
            carrierReg  <= '0;
            deviationReg <= '0;
            bitrateReg  <= '0;
            cicShiftReg <= '0;
        end else if (cs && (byteWr != 4'b0000)) begin
            case (addr)
                regCarrier:   carrierReg   <= mergeBytes(carrierReg, din, byteWr);
                regDeviation: deviationReg <= mergeBytes(deviationReg, din, byteWr);
                regBitrate:   bitrateReg   <= mergeBytes(bitrateReg, din, byteWr);
                regCicShift:  cicShiftReg  <= mergeBytes(cicShiftReg, din, byteWr);
                default: ;
            endcase
        end
    end

    // Readback, one cycle after the access
    always_ff @(posedge clk) begin
        if (cs) begin
            case (addr)
                regCarrier:   dout <= carrierReg;
                regDeviation: dout <= deviationReg;
                regBitrate:   dout <= bitrateReg;
                regCicShift:  dout <= cicShiftReg;
                default:      dout <= '0;
            endcase
        end
    end

    assign cfg.carrierFreq = freqWord_t'(carrierReg);
    assign cfg.deviation   = deviationReg[17:0];
    assign cfg.bitrateDiv  = bitrateReg[15:0];
    assign cfg.modClkSel   = bitrateReg[modClkSelBit];
    assign cfg.cicShift    = cicShiftReg[4:0];

endmodule

`default_nettype wire

/* hw/fmSymbolControl.sv */
`timescale 1ns/1ps
`default_nettype none

module fmSymbolControl
    import fmModRegPkg::*;
    import fmModDataPkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     txSelect,
    input  wire logic     modData,
    input  wire logic     modDataValid,
    input  wire logic     modClkIn,
    input  wire fskMode_e fskMode,
    fmModCfgIf.ctrl       cfg,
    output logic          modClkOut,
    output logic          sampleStrobe,
    output modLevel_t     modValue
);

    bitrateDiv_t bitrateCount;
    logic [2:0]  clkInSync;
    logic        intToggle;
    logic        extToggle;
    logic        extRise;
    logic        bitToggle;
    logic        bitRise;
    logic        modClk;
    logic        fourLevel;
    modLevel_t   bitLevel;
    symPhase_e   symPhase;
    logic        firstBit;

    function automatic modLevel_t dibitLevel(logic [1:0] dibit);
        case (dibit)
            2'b00:   return modLevel_t'(1);
            2'b01:   return modLevel_t'(3);
            2'b10:   return modLevel_t'(-1);
            default: return modLevel_t'(-3);
        endcase
    endfunction

    // Internal divider, toggles every bitrateDiv+1 cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            bitrateCount <= '0;
            modClkOut <= 1'b0;
        end else if (!txSelect) begin
            bitrateCount <= cfg.bitrateDiv;
        end else if (bitrateCount == '0) begin
            bitrateCount <= cfg.bitrateDiv;
            modClkOut <= ~modClkOut;
        end else begin
            bitrateCount <= bitrateCount - 1'b1;
        end
    end

    // External bit clock is asynchronous
    always_ff @(posedge clk) begin
        if (reset) begin
            clkInSync <= '0;
        end else begin
            clkInSync <= {clkInSync[1:0], modClkIn};
        end
    end

    assign intToggle = txSelect && (bitrateCount == '0);
    assign extToggle = txSelect && (clkInSync[2] != clkInSync[1]);
    assign extRise   = txSelect && clkInSync[1] && !clkInSync[2];

    assign bitToggle = cfg.modClkSel ? extToggle : intToggle;
    assign bitRise   = cfg.modClkSel ? extRise : (intToggle && !modClkOut);
    assign modClk    = cfg.modClkSel ? clkInSync[1] : modClkOut;

    assign fourLevel = fskMode inside {mode4Fsk, modeShaped4Fsk};
    assign bitLevel  = modData ? modLevel_t'(2) : modLevel_t'(-2);

    // Two samples per bit in 2FSK, one per bit in 4FSK
    always_ff @(posedge clk) begin
        if (reset) begin
            sampleStrobe <= 1'b0;
        end else begin
            sampleStrobe <= fourLevel ? bitRise : bitToggle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !modDataValid) begin
            modValue <= '0;
            symPhase <= phaseFirst;
        end else if (sampleStrobe) begin
            if (!fourLevel) begin
                // Shaped: zero on the low half of the bit
                if (fskMode == modeShaped2Fsk && !modClk) begin
                    modValue <= '0;
                end else begin
                    modValue <= bitLevel;
                end
            end else begin
                case (symPhase)
                    phaseFirst: begin
                        firstBit <= modData;
                        symPhase <= phaseSecond;
                        if (fskMode == modeShaped4Fsk) begin
                            modValue <= '0;
                        end
                    end
                    phaseSecond: begin
                        modValue <= dibitLevel({firstBit, modData});
                        symPhase <= phaseFirst;
                    end
                    default: symPhase <= phaseFirst;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/shapingFir.sv */
`timescale 1ns/1ps
`default_nettype none

module shapingFir
    import fmModDataPkg::*;
#(
    parameter int firTaps = 8
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      sampleStrobe,
    input  wire modLevel_t modValue,
    output sample_t        shapedSample,
    output logic           shapedStrobe
);

    // Triangular taps 1,3,5.. sum to firTaps^2/2
    localparam int coefSum   = firTaps * firTaps / 2;
    localparam int gainShift = $clog2(coefSum);
    localparam int accWidth  = gainShift + 3;
    localparam int outShift  = 15 - gainShift;

    modLevel_t                   history [firTaps-1];
    logic signed [accWidth-1:0]  acc;

    function automatic int coef(int idx);
        int mirror;
        mirror = firTaps - 1 - idx;
        return 2 * ((idx < mirror) ? idx : mirror) + 1;
    endfunction

    // Newest level enters directly so the output costs one cycle
    always_comb begin
        acc = accWidth'(coef(0)) * accWidth'(modValue);
        for (int i = 1; i < firTaps; i++) begin
            acc = acc + accWidth'(coef(i)) * accWidth'(history[i-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < firTaps - 1; i++) begin
                history[i] <= '0;
            end
            shapedStrobe <= 1'b0;
        end else begin
            shapedStrobe <= sampleStrobe;
            if (sampleStrobe) begin
                history[0] <= modValue;
                for (int i = 1; i < firTaps - 1; i++) begin
                    history[i] <= history[i-1];
                end
            end
        end
    end

    // Unity DC gain: full level sum maps to level * 2^15
    always_ff @(posedge clk) begin
        if (sampleStrobe) begin
            shapedSample <= sample_t'(acc) <<< outShift;
        end
    end

endmodule

`default_nettype wire

/* project.f */
hw/fmModRegPkg.sv
hw/fmModDataPkg.sv
hw/fmModCfgIf.sv
hw/fmModRegs.sv
hw/fmSymbolControl.sv
hw/shapingFir.sv
hw/fmInterpolate.sv
hw/fmDeviation.sv
hw/fmMod.sv
bench/fmModTb.sv

/* run.sh */
#!/bin/sh
# Build and run the FSK modulator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module fmModTb \
    -Mdir obj_dir \
    -o fmModSim

simOutput=$(./obj_dir/fmModSim 2>&1 || true)
printf '%s\n' "$simOutput"

if printf '%s\n' "$simOutput" | grep -qxF '>>> PASS'; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
